/* verification/dbg_ring_router_stim.txt */
# test src port data last : src 0 ring_in 1 local_in; port 0 local_out 1 ring_out (dbg_route_t)
# data in hex, one flit per line, last marks the end of a packet
2 0 0 0003 0
2 0 0 00a1 0
2 0 0 00a2 1
3 0 1 0009 0
3 0 1 00b1 1
4 0 1 0007 0
4 0 1 0c01 0
4 0 1 0c02 1
4 0 1 0008 0
4 0 1 0c11 1
4 1 1 0100 0
4 1 1 0d01 1
4 1 1 0101 0
4 1 1 0d11 0
4 1 1 0d12 1
5 0 0 0003 0
5 0 0 0e01 0
5 0 0 0e02 0
5 0 0 0e03 0
5 0 0 0e04 0
5 0 0 0e05 0
5 0 0 0e06 1
6 0 0 0003 0
6 0 0 0f01 1
6 0 0 0003 0
6 0 0 0f11 1
6 0 1 000a 0
6 0 1 0f21 1
6 0 0 0003 0
6 0 0 0f31 1
6 0 1 0005 1

/* sim.f */
+incdir+hdl
hdl/dbg_flit_pkg.sv
hdl/dbg_route_pkg.sv
hdl/dbg_flit_fifo.sv
hdl/dbg_ring_demux.sv
hdl/dbg_ring_mux.sv
hdl/dbg_ring_router.sv
verification/dbg_ring_router_tb.sv

/* Bender.yml */
package:
  name: dbg_ring_router

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dbg_flit_pkg.sv
      - hdl/dbg_route_pkg.sv
      - hdl/dbg_flit_fifo.sv
      - hdl/dbg_ring_demux.sv
      - hdl/dbg_ring_mux.sv
      - hdl/dbg_ring_router.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - verification/dbg_ring_router_tb.sv

/* verification/dbg_ring_router_tb.sv */
// Run from the project root so the stimulus path resolves; stimulus assumes NODE_ID 0x0003, DEPTH 4
`timescale 1ns/1ps

module dbg_ring_router_tb
  import dbg_flit_pkg::*;
  import dbg_route_pkg::*;
();

  localparam dbg_addr_t NODE_ID = 16'h0003;
  localparam int        DEPTH   = 4;
  localparam int        TIMEOUT = 200;

  // Output ready modes
  localparam int RDY_LOW  = 0;
  localparam int RDY_HIGH = 1;
  localparam int RDY_RAND = 2;

  logic      clk;
  logic      rst;
  dbg_flit_t ring_in;
  logic      ring_in_valid;
  logic      ring_in_ready;
  dbg_flit_t ring_out;
  logic      ring_out_valid;
  logic      ring_out_ready;
  dbg_flit_t local_in;
  logic      local_in_valid;
  logic      local_in_ready;
  dbg_flit_t local_out;
  logic      local_out_valid;
  logic      local_out_ready;

  // Stimulus records with one flit each
  int         st_test[$];
  int         st_src[$];
  dbg_route_t st_port[$];
  dbg_flit_t  st_flit[$];

  // Per-test sources and expected streams
  dbg_flit_t ring_src[$];
  dbg_flit_t local_src[$];
  dbg_flit_t exp_local[$];
  dbg_flit_t exp_fwd[$];
  dbg_flit_t exp_inj[$];

  // Observed streams with ring_out split by source
  dbg_flit_t got_local[$];
  dbg_flit_t got_fwd[$];
  dbg_flit_t got_inj[$];

  int ring_rdy_mode;
  int local_rdy_mode;
  int ring_acc;
  int early_local;
  int check_cnt;
  int err_cnt;
  int cur_test;
  int chk_start;
  int err_start;
  bit out_in_pkt;
  bit out_from_ring;

  dbg_ring_router #(
    .NODE_ID(NODE_ID),
    .DEPTH  (DEPTH)
  ) u_dbg_ring_router (
    .clk            (clk),
    .rst            (rst),
    .ring_in        (ring_in),
    .ring_in_valid  (ring_in_valid),
    .ring_in_ready  (ring_in_ready),
    .ring_out       (ring_out),
    .ring_out_valid (ring_out_valid),
    .ring_out_ready (ring_out_ready),
    .local_in       (local_in),
    .local_in_valid (local_in_valid),
    .local_in_ready (local_in_ready),
    .local_out      (local_out),
    .local_out_valid(local_out_valid),
    .local_out_ready(local_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ########################################
  // Output ready drivers
  // ########################################

  // Output readies follow the mode of each port
  initial begin
    void'($urandom(69019));
    ring_out_ready  = 1'b1;
    local_out_ready = 1'b1;
    forever begin
      @(posedge clk);
      case (ring_rdy_mode)
        RDY_LOW:  ring_out_ready <= 1'b0;
        RDY_HIGH: ring_out_ready <= 1'b1;
        default:  ring_out_ready <= ($urandom % 3) != 0;
      endcase
      case (local_rdy_mode)
        RDY_LOW:  local_out_ready <= 1'b0;
        RDY_HIGH: local_out_ready <= 1'b1;
        default:  local_out_ready <= ($urandom % 3) != 0;
      endcase
    end
  end

  // ########################################
  // Monitors
  // ########################################

  always @(posedge clk) begin
    if (!rst && local_out_valid && local_out_ready) begin
      got_local.push_back(local_out);
    end
    if (!rst && ring_out_valid && ring_out_ready) begin
      // Header decides the source and the rest of the packet follows it
      if (!out_in_pkt) begin
        out_from_ring = (got_fwd.size() < exp_fwd.size()) &&
                        (ring_out === exp_fwd[got_fwd.size()]);
      end
      if (out_from_ring) begin
        got_fwd.push_back(ring_out);
      end else begin
        got_inj.push_back(ring_out);
      end
      out_in_pkt = !ring_out.last;
    end
    // Count of accepted ring flits
    if (!rst && ring_in_valid && ring_in_ready) begin
      ring_acc = ring_acc + 1;
    end
  end

  // ########################################
  // Checks
  // ########################################

  task automatic check_flit(input string name, input dbg_flit_t got, input dbg_flit_t expected);
    check_cnt++;
    if (got !== expected) begin
      err_cnt++;
      $display("Mismatch %s: got data %h last %h, expected data %h last %h",
               name, got.data, got.last, expected.data, expected.last);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic expected);
    check_cnt++;
    if (got !== expected) begin
      err_cnt++;
      $display("Mismatch %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic note_error(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  // ########################################
  // Stimulus
  // ########################################

  task automatic read_stim();
    int        fd;
    int        n;
    int        t;
    int        s;
    int        p;
    int        l;
    dbg_data_t d;
    string     line;
    dbg_flit_t f;
    fd = $fopen("verification/dbg_ring_router_stim.txt", "r");
    if (fd == 0) begin
      note_error("cannot open verification/dbg_ring_router_stim.txt");
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // Lines starting with # describe the columns
      if (n > 0 && line[0] != "#") begin
        n = $sscanf(line, "%d %d %d %h %d", t, s, p, d, l);
        if (n == 5) begin
          f.data = d;
          f.last = l[0];
          st_test.push_back(t);
          st_src.push_back(s);
          st_port.push_back(dbg_route_t'(p[0]));
          st_flit.push_back(f);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic start_test(input int num);
    bit seen_fwd;
    cur_test  = num;
    chk_start = check_cnt;
    err_start = err_cnt;
    seen_fwd  = 1'b0;
    ring_src.delete();
    local_src.delete();
    exp_local.delete();
    exp_fwd.delete();
    exp_inj.delete();
    got_local.delete();
    got_fwd.delete();
    got_inj.delete();
    early_local = 0;
    ring_acc    = 0;
    foreach (st_test[i]) begin
      if (st_test[i] == num) begin
        if (st_src[i] == 1) begin
          // Injected traffic always leaves downstream
          local_src.push_back(st_flit[i]);
          exp_inj.push_back(st_flit[i]);
        end else begin
          ring_src.push_back(st_flit[i]);
          if (st_port[i] == ROUTE_LOCAL) begin
            exp_local.push_back(st_flit[i]);
            if (!seen_fwd) begin
              early_local++;
            end
          end else begin
            exp_fwd.push_back(st_flit[i]);
            seen_fwd = 1'b1;
          end
        end
      end
    end
  endtask

  task automatic finish_test();
    $display("Test %0d finished: %0d checks, %0d failed", cur_test,
             check_cnt - chk_start, err_cnt - err_start);
  endtask

  // Drives one source queue, one flit per accepted transfer
  task automatic send_stream(input bit is_local);
    int   idx;
    int   n;
    int   idle;
    logic accepted;
    idx  = 0;
    idle = 0;
    n    = is_local ? local_src.size() : ring_src.size();
    if (n == 0) begin
      return;
    end
    @(posedge clk);
    while (idx < n && idle < TIMEOUT) begin
      if (is_local) begin
        local_in       <= local_src[idx];
        local_in_valid <= 1'b1;
      end else begin
        ring_in       <= ring_src[idx];
        ring_in_valid <= 1'b1;
      end
      @(posedge clk);
      accepted = is_local ? local_in_ready : ring_in_ready;
      if (accepted) begin
        idx++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (is_local) begin
      local_in_valid <= 1'b0;
    end else begin
      ring_in_valid <= 1'b0;
    end
    if (idx < n) begin
      note_error($sformatf("%s not ready within %0d cycles",
                           is_local ? "local_in" : "ring_in", TIMEOUT));
    end
  endtask

  // ########################################
  // Waits and comparison
  // ########################################

  function automatic bit delivered();
    return got_local.size() >= exp_local.size() && got_fwd.size() >= exp_fwd.size() &&
           got_inj.size() >= exp_inj.size();
  endfunction

  // Timeout restarts whenever a flit arrives
  task automatic wait_delivery();
    int idle;
    int seen;
    idle = 0;
    seen = got_local.size() + got_fwd.size() + got_inj.size();
    while (!delivered() && idle < TIMEOUT) begin
      @(negedge clk);
      if (got_local.size() + got_fwd.size() + got_inj.size() > seen) begin
        seen = got_local.size() + got_fwd.size() + got_inj.size();
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (!delivered()) begin
      note_error($sformatf("no flit on local_out or ring_out within %0d cycles", TIMEOUT));
    end
  endtask

  task automatic compare_all();
    // A few idle cycles to catch stray flits
    repeat (5) @(negedge clk);
    if (got_local.size() != exp_local.size()) begin
      note_error($sformatf("local_out carried %0d flits, expected %0d",
                           got_local.size(), exp_local.size()));
    end
    if (got_fwd.size() != exp_fwd.size()) begin
      note_error($sformatf("ring_out carried %0d forwarded flits, expected %0d",
                           got_fwd.size(), exp_fwd.size()));
    end
    if (got_inj.size() != exp_inj.size()) begin
      note_error($sformatf("ring_out carried %0d injected flits, expected %0d",
                           got_inj.size(), exp_inj.size()));
    end
    foreach (exp_local[i]) begin
      if (i < got_local.size()) check_flit("local_out", got_local[i], exp_local[i]);
    end
    foreach (exp_fwd[i]) begin
      if (i < got_fwd.size()) check_flit("ring_out", got_fwd[i], exp_fwd[i]);
    end
    foreach (exp_inj[i]) begin
      if (i < got_inj.size()) check_flit("ring_out", got_inj[i], exp_inj[i]);
    end
  endtask

  task automatic run_traffic();
    fork
      send_stream(1'b0);
      send_stream(1'b1);
    join
    wait_delivery();
    compare_all();
  endtask

  // FIFO must take exactly DEPTH flits while the demux is blocked
  task automatic watch_fill();
    int cyc;
    cyc = 0;
    while (ring_acc < DEPTH && cyc < TIMEOUT) begin
      @(negedge clk);
      if (ring_acc < DEPTH) check_level("ring_in_ready", ring_in_ready, 1'b1);
      cyc++;
    end
    repeat (4) begin
      check_level("ring_in_ready", ring_in_ready, 1'b0);
      @(negedge clk);
    end
    if (ring_acc != DEPTH) begin
      note_error($sformatf("ring_in accepted %0d flits while local_out was blocked, expected %0d",
                           ring_acc, DEPTH));
    end
  endtask

  // Local-bound packets ahead of the first forwarded one bypass the ring stall
  task automatic watch_bypass();
    int cyc;
    cyc = 0;
    while (got_local.size() < early_local && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (got_local.size() < early_local) begin
      note_error($sformatf("only %0d of %0d local-bound flits passed the ring_out stall",
                           got_local.size(), early_local));
    end
    repeat (3) @(negedge clk);
    // Forwarded header now blocks the FIFO head
    check_level("ring_out_valid", ring_out_valid, 1'b1);
    check_level("local_out_valid", local_out_valid, 1'b0);
    if (exp_fwd.size() > 0) begin
      check_flit("ring_out", ring_out, exp_fwd[0]);
    end
  endtask

  // ########################################
  // Test sequence
  // ########################################

  initial begin
    rst            = 1'b1;
    ring_in        = '0;
    ring_in_valid  = 1'b0;
    local_in       = '0;
    local_in_valid = 1'b0;
    ring_rdy_mode  = RDY_HIGH;
    local_rdy_mode = RDY_HIGH;
    check_cnt      = 0;
    err_cnt        = 0;
    ring_acc       = 0;
    out_in_pkt     = 1'b0;
    out_from_ring  = 1'b0;
    read_stim();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    // Idle state after reset
    start_test(1);
    check_level("local_out_valid", local_out_valid, 1'b0);
    check_level("ring_out_valid", ring_out_valid, 1'b0);
    check_level("ring_in_ready", ring_in_ready, 1'b1);
    check_level("local_in_ready", local_in_ready, 1'b1);
    finish_test();

    // Packet to this node, then a forwarded one
    start_test(2);
    run_traffic();
    finish_test();
    start_test(3);
    run_traffic();
    finish_test();

    // Contention with a stalling downstream ring
    start_test(4);
    ring_rdy_mode = RDY_RAND;
    run_traffic();
    ring_rdy_mode = RDY_HIGH;
    finish_test();

    // Back-pressure from the local module
    start_test(5);
    local_rdy_mode = RDY_LOW;
    fork
      send_stream(1'b0);
      begin
        watch_fill();
        local_rdy_mode = RDY_RAND;
      end
    join
    wait_delivery();
    compare_all();
    local_rdy_mode = RDY_HIGH;
    finish_test();

    // Mixed destinations with the downstream ring stalled
    start_test(6);
    ring_rdy_mode = RDY_LOW;
    fork
      send_stream(1'b0);
      begin
        watch_bypass();
        ring_rdy_mode = RDY_HIGH;
      end
    join
    wait_delivery();
    compare_all();
    finish_test();

    $display("Checks: %0d run, %0d failed", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* hdl/dbg_ring_router.sv */
// One debug ring node; packets whose header equals NODE_ID leave on local_out, others pass on
`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_ring_router
  import dbg_flit_pkg::*;
#(
  parameter dbg_addr_t NODE_ID = '0,
  parameter int        DEPTH   = `DBG_FIFO_DEPTH
) (
  input  logic      clk,
  input  logic      rst,

  // Upstream ring
  input  dbg_flit_t ring_in,
  input  logic      ring_in_valid,
  output logic      ring_in_ready,

  // Downstream ring
  output dbg_flit_t ring_out,
  output logic      ring_out_valid,
  input  logic      ring_out_ready,

  // Local debug module
  input  dbg_flit_t local_in,
  input  logic      local_in_valid,
  output logic      local_in_ready,
  output dbg_flit_t local_out,
  output logic      local_out_valid,
  input  logic      local_out_ready
);

  // Ring FIFO head into demux
  dbg_flit_t ring_q_flit;
  logic      ring_q_valid;
  logic      ring_q_ready;

  // Pass-through traffic into mux
  dbg_flit_t fwd_flit;
  logic      fwd_valid;
  logic      fwd_ready;

  // Local FIFO head into mux
  dbg_flit_t local_q_flit;
  logic      local_q_valid;
  logic      local_q_ready;

  // ########################################
  // Input buffers
  // ########################################

  dbg_flit_fifo #(
    .DEPTH(DEPTH)
  ) ring_fifo (
    .clk      (clk),
    .rst      (rst),
    .in_flit  (ring_in),
    .in_valid (ring_in_valid),
    .in_ready (ring_in_ready),
    .out_flit (ring_q_flit),
    .out_valid(ring_q_valid),
    .out_ready(ring_q_ready)
  );

  dbg_flit_fifo #(
    .DEPTH(DEPTH)
  ) local_fifo (
    .clk      (clk),
    .rst      (rst),
    .in_flit  (local_in),
    .in_valid (local_in_valid),
    .in_ready (local_in_ready),
    .out_flit (local_q_flit),
    .out_valid(local_q_valid),
    .out_ready(local_q_ready)
  );

  // ########################################
  // Routing and merge
  // ########################################

  dbg_ring_demux #(
    .NODE_ID(NODE_ID)
  ) u_demux (
    .clk        (clk),
    .rst        (rst),
    .in_flit    (ring_q_flit),
    .in_valid   (ring_q_valid),
    .in_ready   (ring_q_ready),
    .local_flit (local_out),
    .local_valid(local_out_valid),
    .local_ready(local_out_ready),
    .fwd_flit   (fwd_flit),
    .fwd_valid  (fwd_valid),
    .fwd_ready  (fwd_ready)
  );

  // Forwarded traffic competes with injection
  dbg_ring_mux u_mux (
    .clk        (clk),
    .rst        (rst),
    .ring_flit  (fwd_flit),
    .ring_valid (fwd_valid),
    .ring_ready (fwd_ready),
    .local_flit (local_q_flit),
    .local_valid(local_q_valid),
    .local_ready(local_q_ready),
    .out_flit   (ring_out),
    .out_valid  (ring_out_valid),
    .out_ready  (ring_out_ready)
  );

endmodule

/* hdl/dbg_ring_mux.sv */
// Packet-atomic round-robin merge; once a source is offered it keeps the grant until its last flit
`timescale 1ns/1ps

module dbg_ring_mux
  import dbg_flit_pkg::*;
  import dbg_route_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  dbg_flit_t ring_flit,
  input  logic      ring_valid,
  output logic      ring_ready,

  input  dbg_flit_t local_flit,
  input  logic      local_valid,
  output logic      local_ready,

  output dbg_flit_t out_flit,
  output logic      out_valid,
  input  logic      out_ready
);

  dbg_arb_state_t state;

  // Source that drives the output this cycle
  dbg_arb_state_t sel;

  // Set when the local source won the last contest
  logic last_local;

  logic xfer;

  // ########################################
  // Grant selection
  // ########################################

  always_comb begin
    sel = state;
    if (state == ARB_IDLE) begin
      if (ring_valid && local_valid) begin
        // When both want it the other one gets a turn
        sel = last_local ? ARB_RING : ARB_LOCAL;
      end else if (ring_valid) begin
        sel = ARB_RING;
      end else if (local_valid) begin
        sel = ARB_LOCAL;
      end
    end
  end

  // ########################################
  // Data path
  // ########################################

  always_comb begin
    out_flit  = ring_flit;
    out_valid = 1'b0;
    case (sel)
      ARB_RING: begin
        out_flit  = ring_flit;
        out_valid = ring_valid;
      end
      ARB_LOCAL: begin
        out_flit  = local_flit;
        out_valid = local_valid;
      end
      default: begin
        out_valid = 1'b0;
      end
    endcase
  end

  // Loser sees ready low
  assign ring_ready  = out_ready && (sel == ARB_RING);
  assign local_ready = out_ready && (sel == ARB_LOCAL);

  assign xfer = out_valid & out_ready;

  // ########################################
  // Grant state
  // ########################################

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ARB_IDLE;
      last_local <= 1'b0;
    end else if (state == ARB_IDLE) begin
      if (sel != ARB_IDLE) begin
        // Lock on first offer so the flit on ring_out cannot change under a stall
        last_local <= (sel == ARB_LOCAL);
        if (!(xfer && out_flit.last)) begin
          state <= sel;
        end
      end
    end else if (xfer && out_flit.last) begin
      state <= ARB_IDLE;
    end
  end

  // ########################################
  // Checks
  // ########################################

  a_one_ready: assert property (@(posedge clk) disable iff (rst)
    !(ring_ready && local_ready));

  // Stalled output holds given stable sources and a locked grant
  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_flit));

endmodule

/* hdl/dbg_ring_demux.sv */
// Routes whole ring packets by the header flit; a packet stays on one port until its last flit
`timescale 1ns/1ps

module dbg_ring_demux
  import dbg_flit_pkg::*;
  import dbg_route_pkg::*;
#(
  parameter dbg_addr_t NODE_ID = '0
) (
  input  logic      clk,
  input  logic      rst,

  input  dbg_flit_t in_flit,
  input  logic      in_valid,
  output logic      in_ready,

  output dbg_flit_t local_flit,
  output logic      local_valid,
  input  logic      local_ready,

  output dbg_flit_t fwd_flit,
  output logic      fwd_valid,
  input  logic      fwd_ready
);

  // Held choice for the packet in flight
  dbg_route_t route_q;
  logic       in_packet;

  // Choice that applies to the current head flit
  dbg_route_t route_sel;
  dbg_route_t route_hdr;

  logic xfer;

  // ########################################
  // Route decision
  // ########################################

  // Header compare used only between packets
  assign route_hdr = (dbg_addr_t'(in_flit.data) == NODE_ID) ? ROUTE_LOCAL : ROUTE_FWD;
  assign route_sel = in_packet ? route_q : route_hdr;

  assign xfer = in_valid & in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_packet <= 1'b0;
      route_q   <= ROUTE_FWD;
    end else if (xfer) begin
      if (in_flit.last) begin
        // Next flit after a last flit is a header
        in_packet <= 1'b0;
        route_q   <= ROUTE_FWD;
      end else if (!in_packet) begin
        in_packet <= 1'b1;
        route_q   <= route_hdr;
      end
    end
  end

  // ########################################
  // Data path
  // ########################################

  // Same flit on both sides and valid picks the port
  assign local_flit = in_flit;
  assign fwd_flit   = in_flit;

  assign local_valid = in_valid && (route_sel == ROUTE_LOCAL);
  assign fwd_valid   = in_valid && (route_sel == ROUTE_FWD);

  // Only the chosen port can stall the ring input
  assign in_ready = (route_sel == ROUTE_LOCAL) ? local_ready : fwd_ready;

  // ########################################
  // Checks
  // ########################################

  a_one_port: assert property (@(posedge clk) disable iff (rst)
    !(local_valid && fwd_valid));

endmodule

/* hdl/dbg_flit_fifo.sv */
// Shift-register FIFO with valid/ready; in_ready stays low while full even if a pop is pending
`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_flit_fifo
  import dbg_flit_pkg::*;
#(
  parameter int DEPTH = `DBG_FIFO_DEPTH
) (
  input  logic      clk,
  input  logic      rst,

  input  dbg_flit_t in_flit,
  input  logic      in_valid,
  output logic      in_ready,

  output dbg_flit_t out_flit,
  output logic      out_valid,
  input  logic      out_ready
);

  // Storage with slot 0 at the head
  dbg_flit_t mem      [DEPTH];
  dbg_flit_t mem_next [DEPTH];

  // One-hot fill level with bit 0 empty and bit DEPTH full
  logic [DEPTH:0] fill_ptr;

  logic push;
  logic pop;

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // Head always shows the oldest entry
  assign out_flit  = mem[0];
  assign out_valid = ~fill_ptr[0];
  assign in_ready  = ~fill_ptr[DEPTH];

  // ########################################
  // Fill pointer
  // ########################################

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_ptr <= {{DEPTH{1'b0}}, 1'b1};
    end else if (push && !pop) begin
      fill_ptr <= fill_ptr << 1;
    end else if (pop && !push) begin
      fill_ptr <= fill_ptr >> 1;
    end
  end

  // ########################################
  // Slot update
  // ########################################

  for (genvar i = 0; i < DEPTH; i++) begin : g_slot
    dbg_flit_t shift_src;

    // Top slot has no neighbour above and keeps its own value
    if (i < DEPTH - 1) begin : g_inner
      assign shift_src = mem[i+1];
    end else begin : g_top
      assign shift_src = mem[i];
    end

    // On pop everything moves down one, so the write slot moves down too
    assign mem_next[i] = pop ? ((push && fill_ptr[i+1]) ? in_flit : shift_src)
                             : ((push && fill_ptr[i])   ? in_flit : mem[i]);
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] <= mem_next[i];
    end
  end

  // ########################################
  // Checks
  // ########################################

  // Fill level is always a single position
  a_ptr_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(fill_ptr));

  // Stalled head holds its flit
  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> $stable(out_flit));

endmodule

/* hdl/dbg_route_pkg.sv */
// Routing and arbitration encodings; independent of flit and address width

package dbg_route_pkg;

  // ########################################
  // Demux decision
  // ########################################

  // Per-packet output choice of the ring input
  typedef enum logic [0:0] {
    ROUTE_LOCAL = 1'b0,
    ROUTE_FWD   = 1'b1
  } dbg_route_t;

  // ########################################
  // Mux grant
  // ########################################

  // Which source owns the downstream ring
  typedef enum logic [1:0] {
    ARB_IDLE  = 2'd0,
    ARB_RING  = 2'd1,
    ARB_LOCAL = 2'd2
  } dbg_arb_state_t;

endpackage

/* hdl/dbg_flit_pkg.sv */
// Flit types only; widths come from the settings header, so it must be on the include path
`include "dbg_settings.svh"

package dbg_flit_pkg;

  // ########################################
  // Scalar types
  // ########################################

  // One flit of payload
  typedef logic [`DBG_FLIT_WIDTH-1:0] dbg_data_t;

  // Destination of a packet
  // Compared directly against the first flit's data
  typedef logic [`DBG_ADDR_WIDTH-1:0] dbg_addr_t;

  // ########################################
  // Stream element
  // ########################################

  // Data plus end-of-packet marker in 17 bits
  // Data of a header flit holds the destination
  typedef struct packed {
    dbg_data_t data;
    logic      last;
  } dbg_flit_t;

endpackage

/* hdl/dbg_settings.svh */
// Widths and depth for the debug ring; address width must equal flit width (header = address)
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

// ########################################
// Flit format
// ########################################

// Payload bits per flit
`define DBG_FLIT_WIDTH 16

// Node address carried whole in the first flit
`define DBG_ADDR_WIDTH 16

// ########################################
// Buffering
// ########################################

// Default entries per input FIFO
// Any value of 1 or more is legal
`define DBG_FIFO_DEPTH 4

`endif
